//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath width
`define CORE_DATA_W 16

// Register file and data memory sizes
`define CORE_REG_COUNT 8
`define CORE_MEM_DEPTH 256
`define CORE_SP_RESET 255 // Stack grows down from the top word

// APB port address width
`define CORE_PORT_ADDR_W 8

`endif

//--- common/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [8:0] opcode_t;

	// Field positions in the instruction word
	localparam int OPCODE_LSB = 23;
	localparam int DST_LSB = 20;
	localparam int SRC_LSB = 17;
	localparam int IMM_W = 16; // Immediate sits in the low bits

	localparam opcode_t OP_NOP = 9'b000_000000;
	localparam opcode_t OP_SETC = 9'b000_000001;
	localparam opcode_t OP_CLRC = 9'b000_000010;

	// One operand group
	localparam opcode_t OP_NOT = 9'b001_000000;
	localparam opcode_t OP_INC = 9'b001_000001;
	localparam opcode_t OP_DEC = 9'b001_000010;
	localparam opcode_t OP_OUT = 9'b001_000011;
	localparam opcode_t OP_IN = 9'b001_000100;

	// Two operand group
	localparam opcode_t OP_MOV = 9'b010_000000;
	localparam opcode_t OP_ADD = 9'b010_000001;
	localparam opcode_t OP_SUB = 9'b010_000010;
	localparam opcode_t OP_AND = 9'b010_000011;
	localparam opcode_t OP_OR = 9'b010_000100;
	localparam opcode_t OP_SHL = 9'b010_000101;
	localparam opcode_t OP_SHR = 9'b010_000110;
	localparam opcode_t OP_SHL_IMM = 9'b010_000111;
	localparam opcode_t OP_SHR_IMM = 9'b010_001000;

	// Memory group
	localparam opcode_t OP_PUSH = 9'b011_000000;
	localparam opcode_t OP_POP = 9'b011_000001;
	localparam opcode_t OP_LDM = 9'b011_000010;
	localparam opcode_t OP_LDD = 9'b011_000011;
	localparam opcode_t OP_STD = 9'b011_000100;

	typedef enum logic [3:0] {
		ALU_NOP = 4'b0000,
		ALU_SETC = 4'b0001,
		ALU_CLRC = 4'b0010,
		ALU_PASS_A = 4'b0011, // Operand 1 straight through
		ALU_PASS_B = 4'b0100, // Operand 2 straight through
		ALU_NOT = 4'b0101,
		ALU_INC = 4'b0110,
		ALU_DEC = 4'b0111,
		ALU_ADD = 4'b1000,
		ALU_SUB = 4'b1001,
		ALU_AND = 4'b1010,
		ALU_OR = 4'b1011,
		ALU_SHL = 4'b1100,
		ALU_SHR = 4'b1101
	} alu_func_t;

endpackage

//--- common/core_pkg.sv
package core_pkg;

	`include "core_config.svh"

	typedef logic [`CORE_DATA_W-1:0] data_t;
	typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t;
	typedef logic [$clog2(`CORE_MEM_DEPTH)-1:0] mem_addr_t;

	// Flag bit positions
	typedef logic [2:0] flags_t;
	localparam int FLAG_ZERO = 2;
	localparam int FLAG_NEG = 1;
	localparam int FLAG_CARRY = 0;

	typedef enum logic [1:0] {
		IDLE,
		IO_SETUP,
		IO_ACCESS
	} seq_state_t;

endpackage

//--- rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit import isa_pkg::*; (
	input opcode_t opcode,
	output logic reg_write,
	output logic pass_immediate,
	output logic mem_read,
	output logic mem_write,
	output logic stack_op,
	output logic push_pop,
	output logic io_read,
	output logic io_write,
	output alu_func_t alu_function,
	output logic flag_write
);

	always_comb begin
		// Safe defaults, no latches
		reg_write = 1'b0;
		pass_immediate = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		stack_op = 1'b0;
		push_pop = 1'b0;
		io_read = 1'b0;
		io_write = 1'b0;
		alu_function = ALU_NOP;
		flag_write = 1'b0;
		case (opcode)
			OP_SETC: begin
				alu_function = ALU_SETC;
				flag_write = 1'b1;
			end
			OP_CLRC: begin
				alu_function = ALU_CLRC;
				flag_write = 1'b1;
			end
			OP_NOT, OP_INC, OP_DEC, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SHL, OP_SHR: begin
				reg_write = 1'b1;
				flag_write = 1'b1;
				case (opcode)
					OP_NOT: alu_function = ALU_NOT;
					OP_INC: alu_function = ALU_INC;
					OP_DEC: alu_function = ALU_DEC;
					OP_ADD: alu_function = ALU_ADD;
					OP_SUB: alu_function = ALU_SUB;
					OP_AND: alu_function = ALU_AND;
					OP_OR: alu_function = ALU_OR;
					OP_SHL: alu_function = ALU_SHL;
					default: alu_function = ALU_SHR;
				endcase
			end
			OP_SHL_IMM, OP_SHR_IMM: begin
				alu_function = (opcode == OP_SHL_IMM) ? ALU_SHL : ALU_SHR;
				reg_write = 1'b1;
				pass_immediate = 1'b1; // Shift amount from imm
				flag_write = 1'b1;
			end
			OP_OUT: begin
				alu_function = ALU_PASS_A; // Rdst value onto pwdata
				io_write = 1'b1;
			end
			OP_IN: io_read = 1'b1; // Write-back happens on pready
			OP_MOV: begin
				alu_function = ALU_PASS_B;
				reg_write = 1'b1;
			end
			OP_LDM: begin
				alu_function = ALU_PASS_B;
				reg_write = 1'b1;
				pass_immediate = 1'b1;
			end
			OP_PUSH: begin
				alu_function = ALU_PASS_A;
				mem_write = 1'b1;
				stack_op = 1'b1;
				push_pop = 1'b1;
			end
			OP_POP: begin
				reg_write = 1'b1;
				mem_read = 1'b1;
				stack_op = 1'b1;
			end
			OP_LDD: begin
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			OP_STD: begin
				alu_function = ALU_PASS_A;
				mem_write = 1'b1;
			end
			default: alu_function = ALU_NOP; // NOP and unknown codes
		endcase
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*, isa_pkg::*; (
	input alu_func_t alu_function,
	input data_t operand_a,
	input data_t operand_b,
	input flags_t flags_in,
	output data_t result,
	output flags_t flags_out
);

	localparam int W = $bits(data_t);

	logic [W:0] wide; // Extra bit holds carry or borrow
	logic [3:0] shamt;
	logic carry;
	logic keep_zn;

	assign shamt = operand_b[3:0];

	always_comb begin
		wide = '0;
		result = operand_a;
		carry = flags_in[FLAG_CARRY];
		keep_zn = 1'b0;
		case (alu_function)
			ALU_SETC: begin
				carry = 1'b1;
				keep_zn = 1'b1;
			end
			ALU_CLRC: begin
				carry = 1'b0;
				keep_zn = 1'b1;
			end
			ALU_PASS_A: result = operand_a;
			ALU_PASS_B: result = operand_b;
			ALU_NOT: result = ~operand_a;
			ALU_INC, ALU_DEC, ALU_ADD, ALU_SUB: begin
				case (alu_function)
					ALU_INC: wide = {1'b0, operand_a} + 1'b1;
					ALU_DEC: wide = {1'b0, operand_a} - 1'b1; // Borrow lands in top bit
					ALU_ADD: wide = {1'b0, operand_a} + {1'b0, operand_b};
					default: wide = {1'b0, operand_a} - {1'b0, operand_b};
				endcase
				result = wide[W-1:0];
				carry = wide[W];
			end
			ALU_AND: result = operand_a & operand_b;
			ALU_OR: result = operand_a | operand_b;
			ALU_SHL: begin
				wide = {1'b0, operand_a} << shamt;
				result = wide[W-1:0];
				if (shamt != 4'd0)
					carry = wide[W]; // Last bit out of the top
			end
			ALU_SHR: begin
				wide = {operand_a, 1'b0} >> shamt;
				result = wide[W:1];
				if (shamt != 4'd0)
					carry = wide[0];
			end
			default: keep_zn = 1'b1; // NOP
		endcase
		flags_out[FLAG_CARRY] = carry;
		flags_out[FLAG_ZERO] = keep_zn ? flags_in[FLAG_ZERO] : (result == '0);
		flags_out[FLAG_NEG] = keep_zn ? flags_in[FLAG_NEG] : result[W-1];
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

`include "core_config.svh"

module register_file import core_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_addr_t read_addr_a,
	input reg_addr_t read_addr_b,
	input reg_addr_t write_addr,
	input logic write_enable,
	input data_t write_data,
	output data_t read_data_a,
	output data_t read_data_b
);

	data_t regs [`CORE_REG_COUNT];

	// Asynchronous read ports
	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

	always_ff @(posedge clk) begin
		if (reset)
			regs <= '{default: '0};
		else if (write_enable)
			regs[write_addr] <= write_data;
	end

endmodule

//--- rtl/data_memory.sv
`timescale 1ns/1ps

`include "core_config.svh"

module data_memory import core_pkg::*; (
	input logic clk,
	input logic reset,
	input logic mem_read,
	input logic mem_write,
	input logic stack_op,
	input logic push_pop, // High for push
	input mem_addr_t address,
	input data_t write_data,
	output data_t read_data
);

	data_t mem [`CORE_MEM_DEPTH];
	mem_addr_t sp;
	mem_addr_t sp_inc;
	mem_addr_t rd_addr;
	mem_addr_t wr_addr;
	logic push;
	logic pop;

	assign sp_inc = mem_addr_t'(sp + 1'b1);
	assign push = stack_op && push_pop && mem_write;
	assign pop = stack_op && !push_pop && mem_read;

	// Pop reads above SP before the increment lands
	assign rd_addr = stack_op ? sp_inc : address;
	assign wr_addr = stack_op ? sp : address;
	assign read_data = mem_read ? mem[rd_addr] : '0;

	always_ff @(posedge clk) begin
		if (reset)
			sp <= mem_addr_t'(`CORE_SP_RESET);
		else if (push)
			sp <= sp - 1'b1;
		else if (pop)
			sp <= sp_inc;
	end

	always_ff @(posedge clk) begin
		if (mem_write)
			mem[wr_addr] <= write_data;
	end

	a_no_read_write: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write));

endmodule

//--- rtl/io_apb_master.sv
`timescale 1ns/1ps

`include "core_config.svh"

module io_apb_master import core_pkg::*; (
	input logic clk,
	input logic reset,
	input logic io_read,
	input logic io_write,
	input logic [`CORE_PORT_ADDR_W-1:0] port_addr,
	input data_t write_data,
	output logic io_done,
	output data_t read_data,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [`CORE_PORT_ADDR_W-1:0] paddr,
	output data_t pwdata,
	input data_t prdata,
	input logic pready
);

	seq_state_t state;
	logic req_write;
	logic [`CORE_PORT_ADDR_W-1:0] req_addr;
	data_t req_wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (io_read || io_write) state <= IO_SETUP;
				IO_SETUP: state <= IO_ACCESS; // Setup lasts one cycle
				IO_ACCESS: if (pready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Request fields held for the whole transfer
	always_ff @(posedge clk) begin
		if (state == IDLE && (io_read || io_write)) begin
			req_write <= io_write;
			req_addr <= port_addr;
			req_wdata <= write_data;
		end
	end

	assign psel = (state != IDLE);
	assign penable = (state == IO_ACCESS);
	assign pwrite = req_write;
	assign paddr = req_addr;
	assign pwdata = req_wdata;
	assign io_done = penable && pready;
	assign read_data = prdata; // Sampled by the core on io_done

	// A new request must not arrive while a transfer is in flight
	a_request_when_idle: assert property (@(posedge clk) disable iff (reset)
		(io_read || io_write) |-> !psel);
	a_paddr_stable: assert property (@(posedge clk) disable iff (reset)
		(psel && !io_done) |=> $stable(paddr));

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

`include "core_config.svh"

module core_top import core_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input instr_t instr,
	output logic instr_ready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [`CORE_PORT_ADDR_W-1:0] paddr,
	output data_t pwdata,
	input data_t prdata,
	input logic pready,
	output flags_t flags
);

	opcode_t opcode;
	reg_addr_t dst;
	reg_addr_t src;
	data_t imm;
	logic accept;
	logic cu_reg_write, cu_pass_imm, cu_mem_read, cu_mem_write;
	logic cu_stack_op, cu_push_pop, cu_io_read, cu_io_write, cu_flag_write;
	alu_func_t cu_alu_function;
	data_t rd_a, rd_b, operand_b, alu_result, mem_rdata, io_rdata, wb_data;
	flags_t alu_flags;
	logic io_done, io_busy, io_is_read, wb_enable;
	reg_addr_t io_dst, wb_addr;

	assign opcode = instr[OPCODE_LSB +: $bits(opcode_t)];
	assign dst = instr[DST_LSB +: $bits(reg_addr_t)];
	assign src = instr[SRC_LSB +: $bits(reg_addr_t)];
	assign imm = instr[IMM_W-1:0];
	assign accept = instr_valid && instr_ready;
	assign instr_ready = !io_busy;
	assign operand_b = cu_pass_imm ? imm : rd_b;

	control_unit u_control_unit (.opcode(opcode), .reg_write(cu_reg_write),
		.pass_immediate(cu_pass_imm), .mem_read(cu_mem_read), .mem_write(cu_mem_write),
		.stack_op(cu_stack_op), .push_pop(cu_push_pop), .io_read(cu_io_read),
		.io_write(cu_io_write), .alu_function(cu_alu_function), .flag_write(cu_flag_write));

	alu u_alu (.alu_function(cu_alu_function), .operand_a(rd_a), .operand_b(operand_b),
		.flags_in(flags), .result(alu_result), .flags_out(alu_flags));

	// Write-back from APB read data wins while an IN completes
	assign wb_enable = (cu_reg_write && accept) || (io_done && io_is_read);
	assign wb_addr = io_done ? io_dst : dst;
	assign wb_data = io_done ? io_rdata : (cu_mem_read ? mem_rdata : alu_result);

	register_file u_register_file (.clk(clk), .reset(reset), .read_addr_a(dst),
		.read_addr_b(src), .write_addr(wb_addr), .write_enable(wb_enable),
		.write_data(wb_data), .read_data_a(rd_a), .read_data_b(rd_b));

	data_memory u_data_memory (.clk(clk), .reset(reset), .mem_read(cu_mem_read && accept),
		.mem_write(cu_mem_write && accept), .stack_op(cu_stack_op), .push_pop(cu_push_pop),
		.address(rd_b[$bits(mem_addr_t)-1:0]), .write_data(alu_result), .read_data(mem_rdata));

	io_apb_master u_io_apb_master (.clk(clk), .reset(reset),
		.io_read(cu_io_read && accept), .io_write(cu_io_write && accept),
		.port_addr(imm[`CORE_PORT_ADDR_W-1:0]), .write_data(alu_result), .io_done(io_done),
		.read_data(io_rdata), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready));

	// Issue sequencer and flag register
	always_ff @(posedge clk) begin
		if (reset) begin
			io_busy <= 1'b0;
			flags <= '0;
		end else begin
			if (accept && (cu_io_read || cu_io_write))
				io_busy <= 1'b1;
			else if (io_done)
				io_busy <= 1'b0;
			if (accept && cu_flag_write)
				flags <= alu_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (cu_io_read || cu_io_write)) begin
			io_dst <= dst; // Destination kept for IN
			io_is_read <= cu_io_read;
		end
	end

	a_no_issue_during_apb: assert property (@(posedge clk) disable iff (reset)
		psel |-> !instr_ready);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0; // First rising edge at half a period
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- tests/core_checker.sv
`timescale 1ns/1ps

`include "core_config.svh"

module core_checker import core_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input instr_t instr,
	input logic instr_ready,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`CORE_PORT_ADDR_W-1:0] paddr,
	input data_t pwdata,
	input data_t prdata,
	input logic pready,
	input flags_t flags,
	output int error_count,
	output int check_count
);

	localparam int W = `CORE_DATA_W;

	// Reference state of the core
	data_t regs [`CORE_REG_COUNT];
	data_t mem [`CORE_MEM_DEPTH];
	mem_addr_t sp;
	flags_t exp_flags;
	logic flags_due;
	logic reset_due;

	// Expected fields of the APB transfer in flight
	logic exp_pwrite;
	logic [`CORE_PORT_ADDR_W-1:0] exp_paddr;
	data_t exp_pwdata;
	reg_addr_t in_dst;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
		end
	endtask

	// Register write with zero and negative taken from the new value
	task automatic set_result(input reg_addr_t rd, input data_t value, input logic carry);
		regs[rd] = value;
		exp_flags[FLAG_ZERO] = (value == 0);
		exp_flags[FLAG_NEG] = value[W-1];
		exp_flags[FLAG_CARRY] = carry;
	endtask

	task automatic execute(input instr_t word);
		opcode_t op;
		reg_addr_t rd;
		reg_addr_t rs;
		data_t a;
		data_t b;
		data_t imm;
		logic [W:0] wide;
		int s;
		op = word[31:23];
		rd = word[22:20];
		rs = word[19:17];
		imm = word[15:0];
		a = regs[rd];
		b = regs[rs];
		case (op)
			OP_SETC: exp_flags[FLAG_CARRY] = 1'b1;
			OP_CLRC: exp_flags[FLAG_CARRY] = 1'b0;
			OP_NOT: set_result(rd, ~a, exp_flags[FLAG_CARRY]);
			OP_INC: begin
				wide = a + 17'd1;
				set_result(rd, wide[W-1:0], wide[W]);
			end
			OP_DEC: begin
				wide = a - 17'd1; // Borrow shows in the top bit
				set_result(rd, wide[W-1:0], wide[W]);
			end
			OP_ADD: begin
				wide = a + b;
				set_result(rd, wide[W-1:0], wide[W]);
			end
			OP_SUB: begin
				wide = a - b;
				set_result(rd, wide[W-1:0], wide[W]);
			end
			OP_AND: set_result(rd, a & b, exp_flags[FLAG_CARRY]);
			OP_OR: set_result(rd, a | b, exp_flags[FLAG_CARRY]);
			OP_SHL, OP_SHL_IMM: begin
				s = (op == OP_SHL) ? b[3:0] : imm[3:0];
				set_result(rd, data_t'(a << s), (s == 0) ? exp_flags[FLAG_CARRY] : a[W - s]);
			end
			OP_SHR, OP_SHR_IMM: begin
				s = (op == OP_SHR) ? b[3:0] : imm[3:0];
				set_result(rd, data_t'(a >> s), (s == 0) ? exp_flags[FLAG_CARRY] : a[s - 1]);
			end
			OP_MOV: regs[rd] = b;
			OP_LDM: regs[rd] = imm;
			OP_PUSH: begin
				mem[sp] = a;
				sp = sp - 1'b1;
			end
			OP_POP: begin
				sp = sp + 1'b1;
				regs[rd] = mem[sp];
			end
			OP_LDD: regs[rd] = mem[b[7:0]];
			OP_STD: mem[b[7:0]] = a;
			OP_OUT, OP_IN: begin
				exp_pwrite = (op == OP_OUT);
				exp_paddr = imm[`CORE_PORT_ADDR_W-1:0];
				exp_pwdata = a;
				in_dst = rd;
			end
			default: ; // NOP and unknown codes
		endcase
	endtask

	// All inputs and outputs are settled at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++)
				regs[i] = '0;
			sp = mem_addr_t'(`CORE_SP_RESET);
			exp_flags = '0;
			flags_due = 1'b0;
			reset_due = 1'b1;
		end else begin
			if (reset_due) begin
				compare("instr_ready", 1, instr_ready);
				compare("psel", 0, psel);
				compare("penable", 0, penable);
				compare("flags", 0, flags);
				reset_due = 1'b0;
			end
			if (flags_due)
				compare("flags", exp_flags, flags);
			flags_due = 1'b0;
			if (psel) begin
				check_count++;
				if (instr_ready) begin
					error_count++;
					$display("instr_ready is high during an APB transfer at %0t", $time);
				end
			end
			if (psel && penable && pready) begin // Last cycle of a transfer
				compare("pwrite", exp_pwrite, pwrite);
				compare("paddr", exp_paddr, paddr);
				if (exp_pwrite)
					compare("pwdata", exp_pwdata, pwdata);
				else
					regs[in_dst] = prdata;
			end
			if (instr_valid && instr_ready) begin // Taken on the next rising edge
				execute(instr);
				flags_due = 1'b1;
			end
		end
	end

endmodule

//--- tests/core_tb.sv
`timescale 1ns/1ps

`include "core_config.svh"

module core_tb
	import core_pkg::*, isa_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 5;
	localparam int MAX_INSTR = 200; // Per test
	localparam int CYCLES_PER_INSTR = 6;

	logic clk;
	logic reset;
	logic instr_valid;
	instr_t instr;
	logic instr_ready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`CORE_PORT_ADDR_W-1:0] paddr;
	data_t pwdata;
	data_t prdata;
	logic pready;
	flags_t flags;
	int error_count;
	int check_count;
	int seed;
	int apb_seed;
	int waits_left;
	int test_num;
	int errors_before;

	tb_clock #(.PERIOD(CLK_PERIOD)) clock_gen (.clk(clk));

	core_top uut (.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.instr_ready(instr_ready), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .flags(flags));

	core_checker chk (.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.instr_ready(instr_ready), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .flags(flags),
		.error_count(error_count), .check_count(check_count));

	function automatic instr_t encode(input opcode_t op, input reg_addr_t rd,
		input reg_addr_t rs, input data_t imm);
		return {op, rd, rs, 1'b0, imm};
	endfunction

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'($random(seed));
	endfunction

	function automatic data_t rand_word();
		return data_t'($random(seed));
	endfunction

	function automatic opcode_t pick_alu_op(input int k);
		case (k)
			0: return OP_MOV;
			1: return OP_ADD;
			2: return OP_SUB;
			3: return OP_AND;
			4: return OP_OR;
			5: return OP_NOT;
			6: return OP_INC;
			7: return OP_DEC;
			8: return OP_SHL;
			default: return OP_SHR;
		endcase
	endfunction

	// Holds valid until the core takes the word
	task automatic send(input instr_t word);
		instr = word;
		instr_valid = 1'b1;
		@(negedge clk);
		while (!instr_ready)
			@(negedge clk);
		@(posedge clk);
		#10;
		instr_valid = 1'b0;
	endtask

	task automatic drain();
		@(negedge clk);
		while (!instr_ready || psel)
			@(negedge clk);
		@(negedge clk); // Flags of the last instruction checked here
		@(posedge clk);
		#10;
	endtask

	task automatic report_test(input string name);
		drain();
		$display("Test %0d %s done: %0d errors", test_num, name, error_count - errors_before);
		errors_before = error_count;
		test_num++;
	endtask

	// APB peripheral with 0 to 3 wait states
	always @(posedge clk) begin
		#10;
		if (reset || !psel) begin
			pready = 1'b0;
		end else if (!penable) begin
			waits_left = {$random(apb_seed)} % 4;
			prdata = data_t'($random(apb_seed));
			pready = 1'b0;
		end else if (waits_left == 0) begin
			pready = 1'b1;
		end else begin
			waits_left--;
		end
	end

	initial begin
		#(NUM_TESTS * MAX_INSTR * CYCLES_PER_INSTR * CLK_PERIOD);
		$display("Timeout: the tests did not complete in the expected time");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		reg_addr_t rd;
		data_t value;
		int depth;
		seed = 64;
		apb_seed = 64;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pready = 1'b0;
		prdata = '0;
		test_num = 1;
		errors_before = 0;
		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;
		report_test("reset_values");

		for (int r = 0; r < `CORE_REG_COUNT; r++)
			send(encode(OP_LDM, reg_addr_t'(r), 0, rand_word()));
		repeat (45) begin
			rd = rand_reg();
			send(encode(pick_alu_op({$random(seed)} % 10), rd, rand_reg(), rand_word()));
			send(encode(OP_OUT, rd, 0, rand_word()));
		end
		report_test("alu_register_ops");

		repeat (30) begin
			rd = rand_reg();
			case ({$random(seed)} % 5)
				0: send(encode(OP_SETC, 0, 0, 0));
				1: send(encode(OP_CLRC, 0, 0, 0));
				2: send(encode(OP_LDM, rd, 0, rand_word()));
				3: send(encode(OP_SHL_IMM, rd, rand_reg(), rand_word()));
				default: send(encode(OP_SHR_IMM, rd, rand_reg(), rand_word()));
			endcase
			send(encode(OP_OUT, rd, 0, rand_word()));
		end
		report_test("immediate_and_carry");

		depth = 0;
		repeat (40) begin
			rd = rand_reg();
			if (depth == 0 || (depth < 16 && {$random(seed)} % 2 == 0)) begin
				send(encode(OP_PUSH, rd, 0, 0));
				depth++;
			end else begin
				send(encode(OP_POP, rd, 0, 0));
				send(encode(OP_OUT, rd, 0, rand_word()));
				depth--;
			end
		end
		repeat (15) begin
			value = rand_word();
			send(encode(OP_LDM, 3'd1, 0, rand_word())); // Address in r1
			send(encode(OP_LDM, 3'd2, 0, value));
			send(encode(OP_STD, 3'd2, 3'd1, 0));
			send(encode(OP_LDM, 3'd3, 0, ~value)); // Stale value in r3
			send(encode(OP_LDD, 3'd3, 3'd1, 0));
			send(encode(OP_OUT, 3'd3, 0, rand_word()));
		end
		report_test("stack_and_memory");

		repeat (40) begin
			rd = rand_reg();
			send(encode(OP_IN, rd, 0, rand_word()));
			send(encode(OP_OUT, rd, 0, rand_word()));
		end
		report_test("apb_input");

		$display("Tests run: %0d, checks: %0d, errors: %0d", test_num - 1, check_count,
			error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/data_memory.sv
rtl/io_apb_master.sv
rtl/core_top.sv
tests/tb_clock.sv
tests/core_checker.sv
tests/core_tb.sv
